// File: smartnic_bypass.f
hdl/bypass_pkg.sv
hdl/pkt_drop.sv
hdl/pkt_fifo.sv
hdl/bypass_lane.sv
hdl/pkt_mux.sv
hdl/smartnic_bypass.sv
verification/smartnic_bypass_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := smartnic_bypass_tb
FILELIST   := smartnic_bypass.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/smartnic_bypass_tb.sv
module smartnic_bypass_tb
    import bypass_pkg::*;
();

    typedef enum int {
        FATE_PASS,
        FATE_IGR_DROP,
        FATE_LOOP_DROP
    } fate_t;

    // one row is one packet, plus the switch settings of its group.
    typedef struct {
        int    group;
        int    port;
        int    len;
        port_t tdest;
        port_t tid;
        int    loop_en;
        int    swap;
        int    bp;
        fate_t fate;
    } pkt_desc_t;

    logic        core_clk = 1'b0;
    logic        core_rstn;
    bypass_cfg_t cfg;
    logic        in_valid [2];
    logic        in_ready [2];
    axis_beat_t  in_beat [2];
    logic        out_valid [2];
    logic        out_ready [2];
    axis_beat_t  out_beat [2];
    logic [31:0] igr_drop_count [2];
    logic [31:0] loop_drop_count [2];

    pkt_desc_t   table_q [$];
    axis_beat_t  tx_q [2][$];
    // expected beats, indexed by output * 2 + source port.
    axis_beat_t  exp_q [4][$];
    logic [31:0] exp_igr [2];
    logic [31:0] exp_loop [2];
    logic [31:0] lfsr = 32'h95d0_edcc;
    logic [31:0] rdy_lfsr = 32'h95d0_edcc;
    int          cur_swap;
    int          bp_on;
    int          cycle_cnt = 0;
    int          timeout_limit;

    smartnic_bypass #(
        .FIFO_DEPTH  (64),
        .MAX_PKT_LEN (32)
    ) DUT (
        .core_clk        (core_clk),
        .core_rstn       (core_rstn),
        .cfg             (cfg),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_beat         (in_beat),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_beat        (out_beat),
        .igr_drop_count  (igr_drop_count),
        .loop_drop_count (loop_drop_count)
    );

    always #4 core_clk = ~core_clk;

    // ------------------------------------------------------------------------
    // random numbers and error handling
    // ------------------------------------------------------------------------

    // 32-bit Fibonacci LFSR, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
        if (act !== exp) begin
            fail_stop($sformatf("[FAIL] time %0t %s expected %h actual %h",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            fail_stop($sformatf("[FAIL] time %0t %s expected %0d actual %0d",
                                $time, name, exp, act));
        end
    endtask

    // ------------------------------------------------------------------------
    // packet table
    // ------------------------------------------------------------------------
    function automatic void add_pkt(input int group, input int port, input int len,
                                    input port_t tdest, input port_t tid, input int loop_en,
                                    input int swap, input int bp, input fate_t fate);
        pkt_desc_t d;
        d = '{group, port, len, tdest, tid, loop_en, swap, bp, fate};
        table_q.push_back(d);
    endfunction

    // group, port, len, tdest, tid, loop, swap, back-pressure, fate.
    function automatic void build_table();
        // pass-through.
        add_pkt(0, 0, 4, PORT0, PORT0, 0, 0, 0, FATE_PASS);
        add_pkt(0, 1, 1, PORT1, PORT1, 0, 0, 0, FATE_PASS);
        add_pkt(0, 0, 7, PORT1, PORT0, 0, 0, 0, FATE_PASS);
        add_pkt(0, 1, 3, PORT0, PORT1, 0, 0, 0, FATE_PASS);
        // lanes crossed.
        add_pkt(1, 0, 5, PORT0, PORT0, 0, 1, 0, FATE_PASS);
        add_pkt(1, 1, 2, PORT1, PORT1, 0, 1, 0, FATE_PASS);
        add_pkt(1, 0, 1, PORT0, PORT0, 0, 1, 0, FATE_PASS);
        add_pkt(1, 1, 6, PORT1, PORT1, 0, 1, 0, FATE_PASS);
        // ingress drop code.
        add_pkt(2, 0, 3, DROP,  PORT0, 0, 0, 0, FATE_IGR_DROP);
        add_pkt(2, 0, 4, PORT0, PORT0, 0, 0, 0, FATE_PASS);
        add_pkt(2, 1, 1, DROP,  PORT1, 0, 0, 0, FATE_IGR_DROP);
        add_pkt(2, 1, 5, PORT1, PORT1, 0, 0, 0, FATE_PASS);
        add_pkt(2, 0, 6, DROP,  PORT0, 0, 0, 0, FATE_IGR_DROP);
        // loop drop, straight and crossed, then the same packets with it off.
        add_pkt(3, 0, 4, PORT0, PORT0, 1, 0, 0, FATE_LOOP_DROP);
        add_pkt(3, 0, 3, PORT0, PORT1, 1, 0, 0, FATE_PASS);
        add_pkt(3, 1, 2, PORT1, PORT1, 1, 0, 0, FATE_LOOP_DROP);
        add_pkt(3, 1, 5, PORT1, PORT0, 1, 0, 0, FATE_PASS);
        add_pkt(4, 0, 3, PORT0, PORT1, 1, 1, 0, FATE_LOOP_DROP);
        add_pkt(4, 0, 2, PORT0, PORT0, 1, 1, 0, FATE_PASS);
        add_pkt(4, 1, 4, PORT1, PORT0, 1, 1, 0, FATE_LOOP_DROP);
        add_pkt(4, 1, 1, PORT1, PORT1, 1, 1, 0, FATE_PASS);
        add_pkt(5, 0, 4, PORT0, PORT0, 0, 0, 0, FATE_PASS);
        add_pkt(5, 1, 2, PORT1, PORT1, 0, 0, 0, FATE_PASS);
        // both ports busy under random out_ready.
        add_pkt(6, 0, 8, PORT0, PORT0, 0, 0, 1, FATE_PASS);
        add_pkt(6, 1, 5, PORT1, PORT1, 0, 0, 1, FATE_PASS);
        add_pkt(6, 0, 3, DROP,  PORT0, 0, 0, 1, FATE_IGR_DROP);
        add_pkt(6, 0, 1, PORT0, PORT0, 0, 0, 1, FATE_PASS);
        add_pkt(6, 1, 9, PORT1, PORT1, 0, 0, 1, FATE_PASS);
        add_pkt(6, 0, 12, PORT0, PORT0, 0, 0, 1, FATE_PASS);
        add_pkt(6, 1, 2, PORT1, PORT1, 0, 0, 1, FATE_PASS);
        add_pkt(7, 0, 3, PORT0, PORT0, 0, 1, 1, FATE_PASS);
        add_pkt(7, 1, 7, PORT1, PORT1, 0, 1, 1, FATE_PASS);
        add_pkt(7, 0, 10, PORT0, PORT0, 0, 1, 1, FATE_PASS);
        add_pkt(7, 1, 1, PORT1, PORT1, 0, 1, 1, FATE_PASS);
        add_pkt(7, 1, 4, PORT1, PORT1, 0, 1, 1, FATE_PASS);
    endfunction

    // ------------------------------------------------------------------------
    // stimulus and scoreboard
    // ------------------------------------------------------------------------

    // builds the beats of one group and what each output should deliver.
    task automatic queue_group(input int g);
        pkt_desc_t   d;
        axis_beat_t  beat;
        axis_beat_t  exp;
        logic [63:0] bits;
        int          egr;
        foreach (table_q[k]) begin
            d = table_q[k];
            if (d.group == g) begin
                cfg.drop_pkt_loop = (d.loop_en != 0);
                cfg.swap_paths    = (d.swap != 0);
                cur_swap          = d.swap;
                bp_on             = d.bp;
                egr               = d.port ^ d.swap;
                for (int b = 0; b < d.len; b++) begin
                    beat.tdata = rand_bits(64);
                    bits       = rand_bits(12);
                    beat.tlast = (b == d.len - 1);
                    beat.tkeep = beat.tlast ? (bits[7:0] | 8'h01) : 8'hff;
                    beat.tid   = d.tid;
                    beat.tdest = d.tdest;
                    beat.tuser = bits[11:8];
                    tx_q[d.port].push_back(beat);
                    if (d.fate == FATE_PASS) begin
                        exp       = beat;
                        exp.tdest = (egr == 1) ? PORT1 : PORT0;
                        exp_q[egr * 2 + d.port].push_back(exp);
                    end
                end
                if (d.fate == FATE_IGR_DROP) begin
                    exp_igr[d.port] = exp_igr[d.port] + 32'd1;
                end else if (d.fate == FATE_LOOP_DROP) begin
                    exp_loop[d.port] = exp_loop[d.port] + 32'd1;
                end
            end
        end
    endtask

    task automatic drive_port(input int p);
        logic accepted;
        while (tx_q[p].size() != 0) begin
            in_beat[p]  = tx_q[p].pop_front();
            in_valid[p] = 1'b1;
            accepted    = 1'b0;
            while (!accepted) begin
                @(negedge core_clk);
                accepted = in_ready[p];
                @(posedge core_clk);
                #1;
            end
        end
        in_valid[p] = 1'b0;
    endtask

    // the source of a beat follows from the output and the current swap.
    task automatic take_beat(input int o, input axis_beat_t beat);
        int         idx;
        axis_beat_t exp;
        idx = o * 2 + (o ^ cur_swap);
        if (exp_q[idx].size() == 0) begin
            fail_stop($sformatf("output %0d delivered a beat at time %0t that nothing sent",
                                o, $time));
        end else begin
            exp = exp_q[idx].pop_front();
            check_beat($sformatf("out_beat[%0d]", o), exp, beat);
        end
    endtask

    function automatic logic traffic_done();
        for (int i = 0; i < 4; i++) begin
            if (exp_q[i].size() != 0) begin
                return 1'b0;
            end
        end
        for (int p = 0; p < 2; p++) begin
            if (igr_drop_count[p] < exp_igr[p] || loop_drop_count[p] < exp_loop[p]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic wait_drain();
        while (!traffic_done()) begin
            @(negedge core_clk);
        end
    endtask

    always @(negedge core_clk) begin
        if (core_rstn) begin
            for (int o = 0; o < 2; o++) begin
                if (out_valid[o] && out_ready[o]) begin
                    take_beat(o, out_beat[o]);
                end
            end
        end
    end

    always @(posedge core_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > timeout_limit) begin
            fail_stop($sformatf("timeout, traffic still pending after %0d cycles", cycle_cnt));
        end
    end

    // output back-pressure, random only in groups that ask for it.
    initial begin
        out_ready[0] = 1'b1;
        out_ready[1] = 1'b1;
        forever begin
            @(posedge core_clk);
            #1;
            for (int o = 0; o < 2; o++) begin
                rdy_lfsr     = lfsr_next(rdy_lfsr);
                out_ready[o] = (bp_on != 0) ? rdy_lfsr[0] : 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int last_group;
        int total_beats;
        core_rstn = 1'b0;
        cfg       = '0;
        cur_swap  = 0;
        bp_on     = 0;
        for (int p = 0; p < 2; p++) begin
            in_valid[p] = 1'b0;
            in_beat[p]  = '0;
            exp_igr[p]  = '0;
            exp_loop[p] = '0;
        end
        build_table();
        last_group  = 0;
        total_beats = 0;
        foreach (table_q[k]) begin
            total_beats = total_beats + table_q[k].len;
            if (table_q[k].group > last_group) begin
                last_group = table_q[k].group;
            end
        end
        timeout_limit = total_beats * 4 + 500;

        repeat (16) @(posedge core_clk);
        #1;
        core_rstn = 1'b1;
        for (int p = 0; p < 2; p++) begin
            check_count($sformatf("igr_drop_count[%0d]", p), 32'd0, igr_drop_count[p]);
            check_count($sformatf("loop_drop_count[%0d]", p), 32'd0, loop_drop_count[p]);
        end

        // settings only change once the previous group has drained.
        for (int g = 0; g <= last_group; g++) begin
            queue_group(g);
            fork
                drive_port(0);
                drive_port(1);
            join
            wait_drain();
            for (int p = 0; p < 2; p++) begin
                check_count($sformatf("igr_drop_count[%0d]", p), exp_igr[p],
                            igr_drop_count[p]);
                check_count($sformatf("loop_drop_count[%0d]", p), exp_loop[p],
                            loop_drop_count[p]);
            end
            @(posedge core_clk);
            #1;
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: hdl/smartnic_bypass.sv
module smartnic_bypass
    import bypass_pkg::*;
#(
    parameter int FIFO_DEPTH  = 64,
    parameter int MAX_PKT_LEN = 32
) (
    input  logic        core_clk,
    input  logic        core_rstn,
    input  bypass_cfg_t cfg,

    input  logic        in_valid [2],
    output logic        in_ready [2],
    input  axis_beat_t  in_beat [2],

    output logic        out_valid [2],
    input  logic        out_ready [2],
    output axis_beat_t  out_beat [2],

    output logic [31:0] igr_drop_count [2],
    output logic [31:0] loop_drop_count [2]
);

    // lane streams, indexed [lane][slot].
    logic       lane_valid [2][2];
    logic       lane_ready [2][2];
    axis_beat_t lane_beat  [2][2];

    // mux inputs, indexed [output][input].
    logic       mux_valid [2][2];
    logic       mux_ready [2][2];
    axis_beat_t mux_beat  [2][2];

    for (genvar i = 0; i < 2; i++) begin : g_port
        bypass_lane #(
            .LANE_ID     (port_t'(i)),
            .FIFO_DEPTH  (FIFO_DEPTH),
            .MAX_PKT_LEN (MAX_PKT_LEN)
        ) lane (
            .core_clk        (core_clk),
            .core_rstn       (core_rstn),
            .cfg             (cfg),
            .s_valid         (in_valid[i]),
            .s_ready         (in_ready[i]),
            .s_beat          (in_beat[i]),
            .m_valid         (lane_valid[i]),
            .m_ready         (lane_ready[i]),
            .m_beat          (lane_beat[i]),
            .igr_drop_count  (igr_drop_count[i]),
            .loop_drop_count (loop_drop_count[i])
        );

        // ---------------------------------------------------------------------
        // cross wiring, own slot 0 on input 0 and the other lane's slot 1
        // on input 1.
        // ---------------------------------------------------------------------
        assign mux_valid[i][0]    = lane_valid[i][0];
        assign mux_beat[i][0]     = lane_beat[i][0];
        assign lane_ready[i][0]   = mux_ready[i][0];

        assign mux_valid[i][1]    = lane_valid[1-i][1];
        assign mux_beat[i][1]     = lane_beat[1-i][1];
        assign lane_ready[1-i][1] = mux_ready[i][1];

        pkt_mux mux (
            .core_clk  (core_clk),
            .core_rstn (core_rstn),
            .s_valid   (mux_valid[i]),
            .s_ready   (mux_ready[i]),
            .s_beat    (mux_beat[i]),
            .m_valid   (out_valid[i]),
            .m_ready   (out_ready[i]),
            .m_beat    (out_beat[i])
        );
    end

endmodule

// File: hdl/pkt_mux.sv
module pkt_mux
    import bypass_pkg::*;
(
    input  logic       core_clk,
    input  logic       core_rstn,

    input  logic       s_valid [2],
    output logic       s_ready [2],
    input  axis_beat_t s_beat [2],

    output logic       m_valid,
    input  logic       m_ready,
    output axis_beat_t m_beat
);

    arb_state_t state;
    arb_state_t state_next;
    // index of the input whose packet finished last.
    logic       last_q;
    logic       m_xfer;
    logic       eop;

    assign m_xfer = m_valid && m_ready;
    assign eop    = m_xfer && m_beat.tlast;

    // ------------------------------------------------------------------------
    // grant FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (s_valid[0] && s_valid[1]) begin
                    state_next = last_q ? GRANT0 : GRANT1;
                end else if (s_valid[0]) begin
                    state_next = GRANT0;
                end else if (s_valid[1]) begin
                    state_next = GRANT1;
                end
            end
            // on tlast hand over straight away if the other side waits.
            GRANT0: begin
                if (eop) begin
                    state_next = s_valid[1] ? GRANT1 : IDLE;
                end
            end
            GRANT1: begin
                if (eop) begin
                    state_next = s_valid[0] ? GRANT0 : IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            state  <= IDLE;
            last_q <= 1'b1;
        end else begin
            state <= state_next;
            if (eop) begin
                last_q <= (state == GRANT1);
            end
        end
    end

    // ------------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------------
    assign m_valid = ((state == GRANT0) && s_valid[0]) ||
                     ((state == GRANT1) && s_valid[1]);
    assign m_beat  = (state == GRANT1) ? s_beat[1] : s_beat[0];

    assign s_ready[0] = (state == GRANT0) && m_ready;
    assign s_ready[1] = (state == GRANT1) && m_ready;

    // a stalled output beat must wait, unchanged, for the consumer.
    assert property (@(posedge core_clk) disable iff (!core_rstn)
        m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

// File: hdl/bypass_lane.sv
module bypass_lane
    import bypass_pkg::*;
#(
    parameter port_t LANE_ID     = PORT0,
    parameter int    FIFO_DEPTH  = 64,
    parameter int    MAX_PKT_LEN = 32
) (
    input  logic        core_clk,
    input  logic        core_rstn,
    input  bypass_cfg_t cfg,

    input  logic        s_valid,
    output logic        s_ready,
    input  axis_beat_t  s_beat,

    // slot 0 is this lane's own port, slot 1 the other port.
    output logic        m_valid [2],
    input  logic        m_ready [2],
    output axis_beat_t  m_beat [2],

    output logic [31:0] igr_drop_count,
    output logic [31:0] loop_drop_count
);

    logic       fifo_in_valid;
    logic       fifo_in_ready;
    axis_beat_t fifo_in_beat;

    logic       fifo_out_valid;
    logic       fifo_out_ready;
    axis_beat_t fifo_out_beat;

    axis_beat_t rw_beat;
    port_t      egress;

    logic       demux_valid;
    logic       demux_ready;
    axis_beat_t demux_beat;
    logic       demux_sop;
    logic       sel_now;
    logic       sel_q;
    logic       sel;

    // ------------------------------------------------------------------------
    // ingress drop and packet buffer
    // ------------------------------------------------------------------------
    pkt_drop igr_drop (
        .core_clk   (core_clk),
        .core_rstn  (core_rstn),
        .drop_cond  (s_beat.tdest == DROP),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .s_beat     (s_beat),
        .m_valid    (fifo_in_valid),
        .m_ready    (fifo_in_ready),
        .m_beat     (fifo_in_beat),
        .drop_count (igr_drop_count)
    );

    pkt_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .MAX_PKT_LEN (MAX_PKT_LEN)
    ) bypass_fifo (
        .core_clk  (core_clk),
        .core_rstn (core_rstn),
        .s_valid   (fifo_in_valid),
        .s_ready   (fifo_in_ready),
        .s_beat    (fifo_in_beat),
        .m_valid   (fifo_out_valid),
        .m_ready   (fifo_out_ready),
        .m_beat    (fifo_out_beat)
    );

    // ------------------------------------------------------------------------
    // destination rewrite and loop drop
    // ------------------------------------------------------------------------
    assign egress = port_t'({1'b0, LANE_ID[0] ^ cfg.swap_paths});

    always_comb begin
        rw_beat       = fifo_out_beat;
        rw_beat.tdest = egress;
    end

    pkt_drop loop_drop (
        .core_clk   (core_clk),
        .core_rstn  (core_rstn),
        .drop_cond  (cfg.drop_pkt_loop && (fifo_out_beat.tid == egress)),
        .s_valid    (fifo_out_valid),
        .s_ready    (fifo_out_ready),
        .s_beat     (rw_beat),
        .m_valid    (demux_valid),
        .m_ready    (demux_ready),
        .m_beat     (demux_beat),
        .drop_count (loop_drop_count)
    );

    // ------------------------------------------------------------------------
    // per-packet demux
    // ------------------------------------------------------------------------

    // the first beat picks the slot, the register keeps it for the rest.
    assign sel_now = (demux_beat.tdest != LANE_ID);
    assign sel     = demux_sop ? sel_now : sel_q;

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            demux_sop <= 1'b1;
            sel_q     <= 1'b0;
        end else if (demux_valid && demux_ready) begin
            demux_sop <= demux_beat.tlast;
            if (demux_sop) begin
                sel_q <= sel_now;
            end
        end
    end

    assign m_valid[0]  = demux_valid && !sel;
    assign m_valid[1]  = demux_valid && sel;
    assign m_beat[0]   = demux_beat;
    assign m_beat[1]   = demux_beat;
    assign demux_ready = sel ? m_ready[1] : m_ready[0];

endmodule

// File: hdl/pkt_fifo.sv
module pkt_fifo
    import bypass_pkg::*;
#(
    parameter int FIFO_DEPTH  = 64,
    parameter int MAX_PKT_LEN = 32
) (
    input  logic       core_clk,
    input  logic       core_rstn,

    input  logic       s_valid,
    output logic       s_ready,
    input  axis_beat_t s_beat,

    output logic       m_valid,
    input  logic       m_ready,
    output axis_beat_t m_beat
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    axis_beat_t mem [FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // beats held, committed or not.
    logic [CW-1:0] level;
    // whole packets held, each with its tlast written.
    logic [CW-1:0] pkt_cnt;

    logic full;
    logic wr_en;
    logic rd_en;
    logic wr_eop;
    logic rd_eop;

    assign full    = (level == CW'(FIFO_DEPTH));
    assign s_ready = !full;
    assign wr_en   = s_valid && s_ready;

    // nothing leaves until a complete packet sits in the buffer.
    assign m_valid = (pkt_cnt != '0);
    assign m_beat  = mem[rd_ptr];
    assign rd_en   = m_valid && m_ready;

    assign wr_eop = wr_en && s_beat.tlast;
    assign rd_eop = rd_en && m_beat.tlast;

    // ------------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= s_beat;
        end
    end

    // ------------------------------------------------------------------------
    // pointers and counters
    // ------------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            level   <= '0;
            pkt_cnt <= '0;
        end else begin
            level   <= level + CW'(wr_en) - CW'(rd_en);
            // commit on tlast, so the packet is visible one cycle later.
            pkt_cnt <= pkt_cnt + CW'(wr_eop) - CW'(rd_eop);
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    // a packet longer than the buffer could never commit.
    if (MAX_PKT_LEN > FIFO_DEPTH) begin : g_len_check
        $error("pkt_fifo: MAX_PKT_LEN %0d exceeds FIFO_DEPTH %0d",
               MAX_PKT_LEN, FIFO_DEPTH);
    end

    // the fill level stays within the storage, and every packet holds a beat.
    assert property (@(posedge core_clk) disable iff (!core_rstn)
        level <= CW'(FIFO_DEPTH) && pkt_cnt <= level);

    // with packets no longer than MAX_PKT_LEN a full buffer can always drain.
    assert property (@(posedge core_clk) disable iff (!core_rstn)
        full |-> pkt_cnt != '0);

endmodule

// File: hdl/pkt_drop.sv
module pkt_drop
    import bypass_pkg::*;
(
    input  logic        core_clk,
    input  logic        core_rstn,

    input  logic        drop_cond,

    input  logic        s_valid,
    output logic        s_ready,
    input  axis_beat_t  s_beat,

    output logic        m_valid,
    input  logic        m_ready,
    output axis_beat_t  m_beat,

    output logic [31:0] drop_count
);

    logic       sop_q;
    logic       discard_q;
    logic       drop_now;
    logic       drop_beat;
    logic       s_xfer;
    axis_beat_t beat_q;

    // drop decision is only taken on the first beat of a packet.
    assign drop_now  = sop_q && drop_cond;
    assign drop_beat = discard_q || drop_now;

    // discarded beats never need the output register, so they always go.
    assign s_ready = drop_beat || !m_valid || m_ready;
    assign s_xfer  = s_valid && s_ready;

    assign m_beat = beat_q;

    // ------------------------------------------------------------------------
    // packet tracking and discard
    // ------------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            sop_q      <= 1'b1;
            discard_q  <= 1'b0;
            drop_count <= '0;
        end else if (s_xfer) begin
            sop_q <= s_beat.tlast;
            if (drop_now) begin
                // a single-beat packet is gone already.
                discard_q  <= !s_beat.tlast;
                drop_count <= drop_count + 32'd1;
            end else if (discard_q && s_beat.tlast) begin
                discard_q <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // output register stage
    // ------------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            m_valid <= 1'b0;
        end else if (s_xfer && !drop_beat) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (s_xfer && !drop_beat) begin
            beat_q <= s_beat;
        end
    end

    // a held beat must wait, unchanged, for the consumer.
    assert property (@(posedge core_clk) disable iff (!core_rstn)
        m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

// File: hdl/bypass_pkg.sv
package bypass_pkg;

    // ------------------------------------------------------------------------
    // stream sizing
    // ------------------------------------------------------------------------

    // bytes per beat, sets the tkeep width.
    localparam int DATA_BYTES = 8;
    localparam int DATA_WIDTH = DATA_BYTES * 8;

    // ------------------------------------------------------------------------
    // port codes
    // ------------------------------------------------------------------------

    // used for both the source (tid) and the destination (tdest) of a packet.
    // DROP only has meaning as a destination.
    typedef enum logic [1:0] {
        PORT0 = 2'd0,
        PORT1 = 2'd1,
        DROP  = 2'd3
    } port_t;

    // ------------------------------------------------------------------------
    // stream beat
    // ------------------------------------------------------------------------

    // one beat of a packet stream. valid and ready travel beside it.
    typedef struct packed {
        logic [DATA_WIDTH-1:0] tdata;
        logic [DATA_BYTES-1:0] tkeep;
        logic                  tlast;
        port_t                 tid;
        port_t                 tdest;
        logic [3:0]            tuser;
    } axis_beat_t;

    // ------------------------------------------------------------------------
    // configuration
    // ------------------------------------------------------------------------

    // static switch settings, normally written by software.
    typedef struct packed {
        // drop packets that would return to the port they came from.
        logic drop_pkt_loop;
        // 0 keeps each lane on its own port, 1 crosses the lanes.
        logic swap_paths;
    } bypass_cfg_t;

    // ------------------------------------------------------------------------
    // arbiter state
    // ------------------------------------------------------------------------

    // packet-level grant held by the output mux.
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        GRANT0 = 2'd1,
        GRANT1 = 2'd2
    } arb_state_t;

endpackage
